//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // sv39 virtual instruction address
    localparam int ADDR_W  = 39;
    // one memory read feeds up to two 32-bit slots
    localparam int FETCH_W = 64;
    localparam int INST_W  = 32;
    localparam int ADV_W   = 4;

    localparam logic [ADDR_W-1:0] RESET_ADDR = 39'h40_0000_0000;

    // 32-bit control transfer opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // compressed quadrants holding jumps and branches
    localparam logic [1:0] CQ1 = 2'b01;
    localparam logic [1:0] CQ2 = 2'b10;
    // quadrant 1 funct3 codes
    localparam logic [2:0] CF3_JAL  = 3'b001;
    localparam logic [2:0] CF3_J    = 3'b101;
    localparam logic [2:0] CF3_BEQZ = 3'b110;
    localparam logic [2:0] CF3_BNEZ = 3'b111;
    // quadrant 2 funct4 codes that need rs2 zero
    localparam logic [3:0] CF4_JR   = 4'b1000;
    localparam logic [3:0] CF4_JALR = 4'b1001;

    // legal pc advance amounts in bytes
    localparam logic [ADV_W-1:0] ADV_2 = 4'd2;
    localparam logic [ADV_W-1:0] ADV_4 = 4'd4;
    localparam logic [ADV_W-1:0] ADV_6 = 4'd6;
    localparam logic [ADV_W-1:0] ADV_8 = 4'd8;

    typedef enum logic [2:0] {
        FETCH = 3'h0,
        CACHE = 3'h1,
        VALID = 3'h2,
        RESOL = 3'h3,
        INIT  = 3'h4
    } fetch_state_t;

endpackage

`default_nettype wire

//--- design/inst_align.sv
`timescale 1ns/100ps
`default_nettype none

module inst_align (
    input  logic [fetch_pkg::FETCH_W-1:0] i_fetch_word,
    output logic [fetch_pkg::INST_W-1:0]  o_inst0,
    output logic [fetch_pkg::INST_W-1:0]  o_inst1,
    output logic [1:0]                    o_compressed
);
    import fetch_pkg::*;

    localparam int HALF_W = INST_W / 2;

    logic              c0;
    logic              c1;
    logic [INST_W-1:0] slot0;
    logic [INST_W-1:0] slot1;

    // slot 0 always starts at the bottom of the word
    assign slot0 = i_fetch_word[INST_W-1:0];

    // any low pair other than 2'b11 marks a 16-bit encoding
    assign c0 = slot0[1:0] != 2'b11;

    // slot 1 starts right after slot 0
    // a compressed slot 0 pulls it down by one half-word
    assign slot1 = c0 ? i_fetch_word[INST_W+HALF_W-1:HALF_W]
                      : i_fetch_word[FETCH_W-1:INST_W];

    // slot 1 length from its own low bits
    assign c1 = slot1[1:0] != 2'b11;

    assign o_inst0      = slot0;
    assign o_inst1      = slot1;
    // bit 0 is slot 0
    assign o_compressed = {c1, c0};

endmodule

`default_nettype wire

//--- design/branch_predecode.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predecode (
    input  logic [fetch_pkg::INST_W-1:0] i_inst0,
    input  logic [fetch_pkg::INST_W-1:0] i_inst1,
    input  logic [1:0]                   i_compressed,
    output logic [1:0]                   o_branch,
    output logic                         o_count,
    output logic [fetch_pkg::ADV_W-1:0]  o_advance
);
    import fetch_pkg::*;

    logic [ADV_W-1:0] len0;
    logic [ADV_W-1:0] len1;

    // control transfer check for one slot
    function automatic logic is_cti(
        input logic [INST_W-1:0] inst,
        input logic              compressed
    );
        logic [1:0] quad;
        logic [2:0] funct3;
        logic [3:0] funct4;
        logic       rs1_nz;
        logic       rs2_z;
        logic       cti;

        quad   = inst[1:0];
        funct3 = inst[15:13];
        funct4 = inst[15:12];
        rs1_nz = inst[11:7] != 5'd0;
        rs2_z  = inst[6:2] == 5'd0;
        if (compressed) begin
            case (quad)
                // c.jal, c.j, c.beqz, c.bnez
                CQ1: cti = funct3 inside {CF3_JAL, CF3_J, CF3_BEQZ, CF3_BNEZ};
                // c.jr and c.jalr need a nonzero rs1 since zero is reserved or c.ebreak
                CQ2: cti = (funct4 inside {CF4_JR, CF4_JALR}) && rs1_nz && rs2_z;
                default: cti = 1'b0;
            endcase
        end else begin
            cti = inst[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
        end
        return cti;
    endfunction

    assign o_branch[0] = is_cti(i_inst0, i_compressed[0]);
    assign o_branch[1] = is_cti(i_inst1, i_compressed[1]);

    // no speculation past a slot 0 branch
    // slot 1 only counts when slot 0 falls through
    assign o_count = !o_branch[0];

    // byte length of each slot
    assign len0 = i_compressed[0] ? ADV_2 : ADV_4;
    assign len1 = i_compressed[1] ? ADV_2 : ADV_4;

    // a branch in slot 0 stops the group after that slot
    // a slot 1 branch still gets its own length added
    assign o_advance = o_branch[0] ? len0 : len0 + len1;

    // group length must agree with the count sent to the backend
    always_comb begin
        if (!$isunknown(o_advance)) begin
            a_advance_legal: assert (
                (o_advance inside {ADV_2, ADV_4, ADV_6, ADV_8}) &&
                (o_count || (o_advance <= ADV_4))
            ) else $error("illegal fetch advance %0d, count %0b", o_advance, o_count);
        end
    end

endmodule

`default_nettype wire

//--- design/output_hold.sv
`timescale 1ns/100ps
`default_nettype none

module output_hold (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_mem_valid,
    input  logic                        i_hold,
    input  logic [fetch_pkg::INST_W-1:0] i_inst0,
    input  logic [fetch_pkg::INST_W-1:0] i_inst1,
    input  logic [1:0]                  i_compressed,
    input  logic                        i_count,
    output logic                        o_output_valid,
    output logic [fetch_pkg::INST_W-1:0] o_inst0,
    output logic [fetch_pkg::INST_W-1:0] o_inst1,
    output logic [1:0]                  o_compressed,
    output logic                        o_count
);
    import fetch_pkg::*;

    logic [INST_W-1:0] hold_inst0;
    logic [INST_W-1:0] hold_inst1;
    logic [1:0]        hold_compressed;
    logic              hold_count;

    // snapshot of every group that comes back from memory
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_inst0      <= '0;
            hold_inst1      <= '0;
            hold_compressed <= 2'b00;
            hold_count      <= 1'b0;
        end else if (i_mem_valid) begin
            hold_inst0      <= i_inst0;
            hold_inst1      <= i_inst1;
            hold_compressed <= i_compressed;
            hold_count      <= i_count;
        end
    end

    // zero latency on return, snapshot while the backend stalls
    assign o_output_valid = i_mem_valid || i_hold;
    assign o_inst0        = i_hold ? hold_inst0 : i_inst0;
    assign o_inst1        = i_hold ? hold_inst1 : i_inst1;
    assign o_compressed   = i_hold ? hold_compressed : i_compressed;
    assign o_count        = i_hold ? hold_count : i_count;

    // hold is only entered after a capture, so the first held cycle
    // must match the live group shown the cycle before
    a_hold_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_hold |-> (o_output_valid && $stable(o_inst0) && $stable(o_inst1) &&
                    $stable(o_compressed) && $stable(o_count))
    ) else $error("fetch outputs changed while held");

endmodule

`default_nettype wire

//--- design/fetch_control.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_control (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_mem_valid,
    input  logic                         i_output_valid,
    input  logic                         i_output_ready,
    input  logic [1:0]                   i_branch,
    input  logic [fetch_pkg::ADV_W-1:0]  i_advance,
    input  logic                         i_branch_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] i_branch_target,
    output logic                         o_mem_ren,
    output logic [fetch_pkg::ADDR_W-1:0] o_mem_raddr,
    output logic                         o_hold
);
    import fetch_pkg::*;

    fetch_state_t      state;
    fetch_state_t      next_state;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] next_pc;
    logic [ADDR_W-1:0] adv_pc;

    // predecode of the returned word is kept for the VALID state
    // since memory data is only live in the return cycle
    logic              held_branched;
    logic [ADV_W-1:0]  held_advance;
    logic              branched;
    logic [ADV_W-1:0]  advance;

    logic              sent;
    logic              target_taken;
    // request in flight for the one-request check
    logic              req_pending;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= INIT;
            pc    <= RESET_ADDR;
        end else begin
            state <= next_state;
            pc    <= next_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_mem_valid) begin
            held_branched <= |i_branch;
            held_advance  <= i_advance;
        end
    end

    assign o_hold = state == VALID;

    // live predecode on return, the saved copy while holding
    assign branched = o_hold ? held_branched : |i_branch;
    assign advance  = o_hold ? held_advance : i_advance;

    // group goes out when presented and accepted
    assign sent = i_output_valid && i_output_ready;

    // target only counts while actually waiting for it
    assign target_taken = (state == RESOL) && i_branch_valid;

    assign adv_pc = pc + {{(ADDR_W-ADV_W){1'b0}}, advance};

    // FETCH   request issued, waiting for memory or sending now
    // CACHE   memory still busy, nothing presented
    // VALID   group presented but backend not ready
    // RESOL   group with a branch sent, waiting for the target
    // INIT    first cycle after reset, starts the first request
    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                next_state = FETCH;
            end
            FETCH, CACHE, VALID: begin
                if (sent) begin
                    next_state = branched ? RESOL : FETCH;
                end else if (i_output_valid) begin
                    next_state = VALID;
                end else begin
                    next_state = CACHE;
                end
            end
            RESOL: begin
                if (i_branch_valid) begin
                    next_state = FETCH;
                end
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

    // pc only moves on a send or on the resolved target
    always_comb begin
        next_pc = pc;
        if (target_taken) begin
            next_pc = i_branch_target;
        end else if ((state != RESOL) && sent) begin
            next_pc = adv_pc;
        end
    end

    // every entry into FETCH is exactly one new request
    // reset keeps the request low until the first cycle of INIT
    assign o_mem_ren   = i_rst_n && (next_state == FETCH);
    // request carries the address the pc register takes next
    assign o_mem_raddr = next_pc;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_pending <= 1'b0;
        end else if (o_mem_ren) begin
            req_pending <= 1'b1;
        end else if (i_mem_valid) begin
            req_pending <= 1'b0;
        end
    end

    // a new read may only go out once the previous one returned
    // or in the return cycle itself
    a_one_request: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_mem_ren |-> (!req_pending || i_mem_valid)
    ) else $error("memory request issued while one is outstanding");

    // no send and no target means no pc movement
    a_pc_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (!sent && !target_taken) |=> $stable(pc)
    ) else $error("pc moved without a send or a branch target");

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    // instruction memory with one read in flight
    output logic                          o_mem_ren,
    output logic [fetch_pkg::ADDR_W-1:0]  o_mem_raddr,
    input  logic                          i_mem_valid,
    input  logic [fetch_pkg::FETCH_W-1:0] i_mem_rdata,
    // resolved target from the backend
    input  logic                          i_branch_valid,
    input  logic [fetch_pkg::ADDR_W-1:0]  i_branch_target,
    // fetch group towards decode
    input  logic                          i_output_ready,
    output logic                          o_output_valid,
    output logic [fetch_pkg::INST_W-1:0]  o_inst0,
    output logic [fetch_pkg::INST_W-1:0]  o_inst1,
    output logic [1:0]                    o_compressed,
    output logic                          o_count
);
    import fetch_pkg::*;

    logic [INST_W-1:0] inst0;
    logic [INST_W-1:0] inst1;
    logic [1:0]        compressed;
    logic [1:0]        branch;
    logic              count;
    logic [ADV_W-1:0]  advance;
    logic              hold;

    inst_align inst_align_i (
        .i_fetch_word (i_mem_rdata),
        .o_inst0      (inst0),
        .o_inst1      (inst1),
        .o_compressed (compressed)
    );

    branch_predecode branch_predecode_i (
        .i_inst0      (inst0),
        .i_inst1      (inst1),
        .i_compressed (compressed),
        .o_branch     (branch),
        .o_count      (count),
        .o_advance    (advance)
    );

    // backend outputs all come from the hold stage
    output_hold output_hold_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_valid    (i_mem_valid),
        .i_hold         (hold),
        .i_inst0        (inst0),
        .i_inst1        (inst1),
        .i_compressed   (compressed),
        .i_count        (count),
        .o_output_valid (o_output_valid),
        .o_inst0        (o_inst0),
        .o_inst1        (o_inst1),
        .o_compressed   (o_compressed),
        .o_count        (o_count)
    );

    fetch_control fetch_control_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_mem_valid     (i_mem_valid),
        .i_output_valid  (o_output_valid),
        .i_output_ready  (i_output_ready),
        .i_branch        (branch),
        .i_advance       (advance),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target),
        .o_mem_ren       (o_mem_ren),
        .o_mem_raddr     (o_mem_raddr),
        .o_hold          (hold)
    );

endmodule

`default_nettype wire

//--- bench/fetch_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_checker (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_mem_ren,
    input  logic [fetch_pkg::ADDR_W-1:0] i_mem_raddr,
    input  logic                         i_mem_valid,
    input  logic                         i_branch_valid,
    input  logic                         i_output_ready,
    input  logic                         i_output_valid,
    input  logic [fetch_pkg::INST_W-1:0] i_inst0,
    input  logic [fetch_pkg::INST_W-1:0] i_inst1,
    input  logic [1:0]                   i_compressed,
    input  logic                         i_count,
    // expected group and next read address for the current row
    input  logic [fetch_pkg::INST_W-1:0] i_exp_inst0,
    input  logic [fetch_pkg::INST_W-1:0] i_exp_inst1,
    input  logic [1:0]                   i_exp_compressed,
    input  logic                         i_exp_count,
    input  logic                         i_exp_branch,
    input  logic [fetch_pkg::ADDR_W-1:0] i_exp_raddr,
    input  logic                         i_done,
    output int                           o_error_count,
    output int                           o_test_count
);
    import fetch_pkg::*;

    int   errors = 0;
    int   row_errors = 0;
    int   tests = 0;
    int   passed = 0;
    int   checks = 0;
    // reads issued and groups sent must alternate
    int   reqs = 0;
    int   sends = 0;
    logic waiting_target = 1'b0;
    // group returned from memory but not yet taken by the backend
    logic group_pending = 1'b0;
    logic reported = 1'b0;

    assign o_error_count = errors;
    assign o_test_count  = tests;

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
            row_errors++;
            errors++;
        end
    endtask

    task automatic flag_problem(input string what);
        $display("t=%0t %s", $time, what);
        row_errors++;
        errors++;
    endtask

    // a row ends at the read that follows its send
    task automatic close_test();
        if (reqs == 0) begin
            $display("test %0d reset and first read: %s", tests, row_errors ? "failed" : "ok");
        end else begin
            $display("test %0d fetch group %0d: %s", tests, reqs - 1,
                     row_errors ? "failed" : "ok");
        end
        if (row_errors == 0) begin
            passed++;
        end
        tests++;
        row_errors = 0;
    endtask

    // all DUT outputs have settled by the falling edge
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            if (i_mem_ren || i_output_valid) begin
                flag_problem("read request or output valid raised during reset");
            end
        end else begin
            // valid rises with the memory return and stays up until the send
            compare("o_output_valid", 64'(i_mem_valid || group_pending), 64'(i_output_valid));
            if (i_output_valid) begin
                if (reqs == sends) begin
                    flag_problem("output valid high with no read outstanding");
                end
                compare("o_inst0", 64'(i_exp_inst0), 64'(i_inst0));
                compare("o_inst1", 64'(i_exp_inst1), 64'(i_inst1));
                compare("o_compressed", 64'(i_exp_compressed), 64'(i_compressed));
                compare("o_count", 64'(i_exp_count), 64'(i_count));
                if (i_output_ready) begin
                    sends++;
                    waiting_target = i_exp_branch;
                    group_pending = 1'b0;
                end else begin
                    group_pending = 1'b1;
                end
            end
            if (i_mem_ren) begin
                if (waiting_target && !i_branch_valid) begin
                    flag_problem("read issued before the branch target arrived");
                end
                if (reqs != sends) begin
                    flag_problem("extra read issued before the group was sent");
                end
                compare("o_mem_raddr", 64'(i_exp_raddr), 64'(i_mem_raddr));
                close_test();
                reqs++;
            end
            if (i_branch_valid) begin
                waiting_target = 1'b0;
            end
            if (i_done && !reported) begin
                $display("tests %0d: %0d passed, %0d failed; %0d checks, %0d errors",
                         tests, passed, tests - passed, checks, errors);
                reported = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int NUM_ROWS = 10;
    // worst row is about 12 cycles plus margin for reset and the tail
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 16 + 20;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               mem_valid;
    logic [FETCH_W-1:0] mem_rdata;
    logic               branch_valid;
    logic [ADDR_W-1:0]  branch_target;
    logic               output_ready;
    logic               mem_ren;
    logic [ADDR_W-1:0]  mem_raddr;
    logic               output_valid;
    logic [INST_W-1:0]  inst0;
    logic [INST_W-1:0]  inst1;
    logic [1:0]         compressed;
    logic               count;

    // expectations handed to the checker
    logic [INST_W-1:0]  exp_inst0;
    logic [INST_W-1:0]  exp_inst1;
    logic [1:0]         exp_compressed;
    logic               exp_count;
    logic               exp_branch;
    logic [ADDR_W-1:0]  exp_raddr;
    logic               done;
    int                 error_count;
    int                 test_count;
    int                 cycles = 0;

    // stimulus table, one fetch group per row
    logic [FETCH_W-1:0] tab_word [NUM_ROWS];
    logic [INST_W-1:0]  tab_inst0 [NUM_ROWS];
    logic [INST_W-1:0]  tab_inst1 [NUM_ROWS];
    logic [1:0]         tab_comp [NUM_ROWS];
    logic               tab_count [NUM_ROWS];
    logic               tab_branch [NUM_ROWS];
    logic [ADDR_W-1:0]  tab_target [NUM_ROWS];
    logic [ADDR_W-1:0]  tab_next [NUM_ROWS];
    int                 tab_tdelay [NUM_ROWS];
    int                 tab_lat [NUM_ROWS];
    int                 tab_stall [NUM_ROWS];
    int                 row_num = 0;
    logic [ADDR_W-1:0]  pc_model = RESET_ADDR;

    fetch_top fetch_top_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .o_mem_ren       (mem_ren),
        .o_mem_raddr     (mem_raddr),
        .i_mem_valid     (mem_valid),
        .i_mem_rdata     (mem_rdata),
        .i_branch_valid  (branch_valid),
        .i_branch_target (branch_target),
        .i_output_ready  (output_ready),
        .o_output_valid  (output_valid),
        .o_inst0         (inst0),
        .o_inst1         (inst1),
        .o_compressed    (compressed),
        .o_count         (count)
    );

    fetch_checker fetch_checker_i (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_mem_ren        (mem_ren),
        .i_mem_raddr      (mem_raddr),
        .i_mem_valid      (mem_valid),
        .i_branch_valid   (branch_valid),
        .i_output_ready   (output_ready),
        .i_output_valid   (output_valid),
        .i_inst0          (inst0),
        .i_inst1          (inst1),
        .i_compressed     (compressed),
        .i_count          (count),
        .i_exp_inst0      (exp_inst0),
        .i_exp_inst1      (exp_inst1),
        .i_exp_compressed (exp_compressed),
        .i_exp_count      (exp_count),
        .i_exp_branch     (exp_branch),
        .i_exp_raddr      (exp_raddr),
        .i_done           (done),
        .o_error_count    (error_count),
        .o_test_count     (test_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles, fetch loop is stuck", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // next pc is the target on a branch, else pc plus the group length
    task automatic add_row(input logic [FETCH_W-1:0] word, input logic [INST_W-1:0] i0,
                           input logic [INST_W-1:0] i1, input logic [1:0] comp,
                           input logic cnt, input logic [3:0] adv, input logic br,
                           input logic [ADDR_W-1:0] target, input int tdelay);
        tab_word[row_num]   = word;
        tab_inst0[row_num]  = i0;
        tab_inst1[row_num]  = i1;
        tab_comp[row_num]   = comp;
        tab_count[row_num]  = cnt;
        tab_branch[row_num] = br;
        tab_target[row_num] = target;
        tab_tdelay[row_num] = tdelay;
        tab_next[row_num]   = br ? target : pc_model + ADDR_W'(adv);
        pc_model            = tab_next[row_num];
        tab_lat[row_num]    = 1 + int'($urandom % 4);
        tab_stall[row_num]  = int'($urandom % 4);
        row_num++;
    endtask

    // one-cycle pulses drop back low just after the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
        mem_valid    = 1'b0;
        branch_valid = 1'b0;
        output_ready = 1'b0;
    endtask

    // sample on the falling edge until the DUT issues a read
    task automatic await_request();
        @(negedge clk);
        while (!mem_ren) begin
            step();
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(45566));
        rst_n          = 1'b0;
        mem_valid      = 1'b0;
        mem_rdata      = '0;
        branch_valid   = 1'b0;
        branch_target  = '0;
        output_ready   = 1'b0;
        done           = 1'b0;
        exp_inst0      = '0;
        exp_inst1      = '0;
        exp_compressed = 2'b00;
        exp_count      = 1'b0;
        exp_branch     = 1'b0;
        exp_raddr      = RESET_ADDR;

        // two full-width, then compressed then full, then both compressed
        add_row(64'h00208113_00100093, 32'h00100093, 32'h00208113, 2'b00, 1'b1, 4'd8,
                1'b0, '0, 0);
        add_row(64'hABCD_0010_0093_0085, 32'h00930085, 32'h00100093, 2'b01, 1'b1, 4'd6,
                1'b0, '0, 0);
        add_row(64'h0000_0001_808A_4085, 32'h808A4085, 32'h0001808A, 2'b11, 1'b1, 4'd4,
                1'b0, '0, 0);
        // beq in slot 0, c.beqz in slot 0, jal in slot 1
        add_row(64'h00100093_00000463, 32'h00000463, 32'h00100093, 2'b00, 1'b0, 4'd4,
                1'b1, 39'h40_0000_1000, 1);
        add_row(64'h0000_0010_0093_C001, 32'h0093C001, 32'h00100093, 2'b01, 1'b0, 4'd2,
                1'b1, 39'h40_0000_2002, 2);
        add_row(64'h008000EF_00100093, 32'h00100093, 32'h008000EF, 2'b00, 1'b1, 4'd8,
                1'b1, 39'h40_0000_3000, 3);
        // full then compressed, and c.ebreak which is no jump
        add_row(64'h1111_0085_0020_8113, 32'h00208113, 32'h11110085, 2'b10, 1'b1, 4'd6,
                1'b0, '0, 0);
        add_row(64'h0000_0000_0001_9002, 32'h00019002, 32'h00000001, 2'b11, 1'b1, 4'd4,
                1'b0, '0, 0);
        // c.jr in slot 1, then jalr in slot 0
        add_row(64'h0000_0001_8082_4085, 32'h80824085, 32'h00018082, 2'b11, 1'b1, 4'd4,
                1'b1, 39'h40_0000_4010, 1);
        add_row(64'h00100093_00008067, 32'h00008067, 32'h00100093, 2'b00, 1'b0, 4'd4,
                1'b1, 39'h40_0000_5004, 2);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            await_request();
            repeat (tab_lat[r]) step();
            // memory answers and ready may follow a few cycles later
            mem_valid      = 1'b1;
            mem_rdata      = tab_word[r];
            output_ready   = (tab_stall[r] == 0);
            exp_inst0      = tab_inst0[r];
            exp_inst1      = tab_inst1[r];
            exp_compressed = tab_comp[r];
            exp_count      = tab_count[r];
            exp_branch     = tab_branch[r];
            exp_raddr      = tab_next[r];
            for (int s = 1; s <= tab_stall[r]; s++) begin
                step();
                output_ready = (s == tab_stall[r]);
            end
            if (tab_branch[r]) begin
                repeat (tab_tdelay[r]) step();
                branch_valid  = 1'b1;
                branch_target = tab_target[r];
            end
        end
        // read after the last group closes the last row
        await_request();
        step();
        done = 1'b1;
        @(negedge clk);
        #1;
        if (error_count == 0 && test_count == NUM_ROWS + 1) begin
            $display("PASS: all tests");
        end else begin
            if (test_count != NUM_ROWS + 1) begin
                $display("only %0d of %0d tests completed", test_count, NUM_ROWS + 1);
            end
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/fetch_pkg.sv
design/inst_align.sv
design/branch_predecode.sv
design/output_hold.sv
design/fetch_control.sv
design/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

//--- Makefile
# fetch unit simulation with Verilator

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/fetch_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
